//--- Bender.yml
package:
  name: sifh_histogram

sources:
  - design/sifhPkg.sv
  - design/histMemIf.sv
  - design/histRam.sv
  - design/histogramFsm.sv
  - design/peakTracker.sv
  - design/sifhHistogram.sv
  - target: test
    files:
      - tests/sifhHistogram_properties.sv
      - tests/sifhHistogramTb.sv

//--- design/histMemIf.sv
interface histMemIf import sifhPkg::*; ();

    // write port, new counts
    logic [addrWidth-1:0]  waddr;
    logic                  wEnable;
    logic [countWidth-1:0] wdata;

    // read port, stored counts
    logic [addrWidth-1:0]  raddr;
    logic                  rEnable;
    logic [countWidth-1:0] rdata;

    // histogram controller side
    modport ctrl (output waddr, wEnable, wdata, raddr, rEnable, input rdata);

    // RAM side
    modport mem (input waddr, wEnable, wdata, raddr, rEnable, output rdata);

    // write traffic observer for the peak tracker
    modport mon (input waddr, wEnable, wdata);

endinterface

//--- design/histRam.sv
module histRam import sifhPkg::*; (
    input logic   clk,
    histMemIf.mem mem
);

    // histogram storage
    // no reset, cleared by the controller sweep
    logic [countWidth-1:0] words [ramDepth];

    // write port
    always_ff @(posedge clk) begin
        if (mem.wEnable) begin
            words[mem.waddr] <= mem.wdata;
        end
    end

    // read port with output register
    // same-cycle read of a written address returns the old word
    always_ff @(posedge clk) begin
        if (mem.rEnable) begin
            mem.rdata <= words[mem.raddr];
        end
    end

endmodule

//--- design/histogramFsm.sv
module histogramFsm import sifhPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  clear,
    input  logic                  wrEn,
    input  logic [pixelWidth-1:0] pixel,
    input  logic [stampWidth-1:0] data,
    output logic                  busy,
    histMemIf.ctrl                mem
);

    // two states: sweeping (1) or running (0)
    logic sweeping;

    // set by reset, starts the first sweep after release
    logic initPending;

    // sweep write pointer
    logic [addrWidth-1:0] sweepAddr;
    logic                 sweepLast;

    // hit accepted this cycle
    logic                 accept;
    logic [addrWidth-1:0] readAddr;

    // stage holding the hit that waits for its write
    logic                 stageValid;
    logic [addrWidth-1:0] stageAddr;

    // forwarded count when the next hit reads the address just written
    logic                  fwdValid;
    logic [countWidth-1:0] fwdCount;

    // increment path
    logic [countWidth-1:0] baseCount;
    logic [countWidth-1:0] newCount;

    assign busy = sweeping;

    // hits ignored while busy and until the first sweep has started
    assign accept = wrEn && !sweeping && !initPending;

    // address is pixel index then timestamp upper bits
    assign readAddr = {pixel, data[stampWidth-1 -: binWidth]};

    assign sweepLast = (sweepAddr == addrWidth'(ramDepth - 1));

    // old data from RAM on a same-address read, so take our own write value
    assign baseCount = fwdValid ? fwdCount : mem.rdata;

    // saturating increment
    assign newCount = (baseCount == {countWidth{1'b1}}) ? baseCount
                                                        : baseCount + countWidth'(1);

    // read side
    assign mem.raddr   = readAddr;
    assign mem.rEnable = accept;

    // write side, sweep zeroes or pipeline writes count + 1
    assign mem.wEnable = sweeping || stageValid;
    assign mem.waddr   = sweeping ? sweepAddr : stageAddr;
    assign mem.wdata   = sweeping ? '0 : newCount;

    // state, sweep counter and stage valid
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sweeping    <= 1'b0;
            initPending <= 1'b1;
            sweepAddr   <= '0;
            stageValid  <= 1'b0;
            fwdValid    <= 1'b0;
        end else begin
            stageValid <= 1'b0;
            fwdValid   <= 1'b0;
            if (sweeping) begin
                // one zero write per cycle over the whole RAM
                sweepAddr <= sweepAddr + addrWidth'(1);
                if (sweepLast) begin
                    sweeping <= 1'b0;
                end
            end else if (initPending || clear) begin
                // a hit taken on this edge is dropped, its write falls in the sweep
                sweeping    <= 1'b1;
                initPending <= 1'b0;
                sweepAddr   <= '0;
            end else begin
                stageValid <= accept;
                fwdValid   <= accept && stageValid && (readAddr == stageAddr);
            end
        end
    end

    // payload of the stage and the forward register
    always_ff @(posedge clk) begin
        if (accept) begin
            stageAddr <= readAddr;
        end
        fwdCount <= newCount;
    end

endmodule

//--- design/peakTracker.sv
module peakTracker import sifhPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  clear,
    input  logic                  busy,
    input  logic [pixelWidth-1:0] peakSel,
    histMemIf.mon                 mem,
    output logic [binWidth-1:0]   peakBin,
    output logic [countWidth-1:0] peakCount
);

    // best count and its bin, one pair per pixel
    logic [countWidth-1:0] bestCount [pixelCount];
    logic [binWidth-1:0]   bestBin   [pixelCount];

    // split the write address back into pixel and bin
    logic [pixelWidth-1:0] wrPixel;
    logic [binWidth-1:0]   wrBin;

    assign wrPixel = mem.waddr[addrWidth-1 -: pixelWidth];
    assign wrBin   = mem.waddr[binWidth-1:0];

    always_ff @(posedge clk) begin
        if (!rstN || (clear && !busy)) begin
            // clear follows the controller, which starts its sweep on the same edge
            for (int i = 0; i < pixelCount; i++) begin
                bestCount[i] <= '0;
                bestBin[i]   <= '0;
            end
        end else if (mem.wEnable && !busy) begin
            // strictly greater only, ties keep the earlier bin
            if (mem.wdata > bestCount[wrPixel]) begin
                bestCount[wrPixel] <= mem.wdata;
                bestBin[wrPixel]   <= wrBin;
            end
        end
    end

    // readout mux
    assign peakBin   = bestBin[peakSel];
    assign peakCount = bestCount[peakSel];

endmodule

//--- design/sifhHistogram.sv
module sifhHistogram import sifhPkg::*; (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  clear,
    input  logic                  wrEn,
    input  logic [pixelWidth-1:0] pixel,
    input  logic [stampWidth-1:0] data,
    input  logic [pixelWidth-1:0] peakSel,
    output logic                  busy,
    output logic [binWidth-1:0]   peakBin,
    output logic [countWidth-1:0] peakCount
);

    // shared histogram RAM bus
    histMemIf memBus ();

    // clear sweep and read-modify-write increment
    histogramFsm fsm (
        .clk   (clk),
        .rstN  (rstN),
        .clear (clear),
        .wrEn  (wrEn),
        .pixel (pixel),
        .data  (data),
        .busy  (busy),
        .mem   (memBus.ctrl)
    );

    // counts for all pixels and bins
    histRam ram (
        .clk (clk),
        .mem (memBus.mem)
    );

    // per-pixel peak from the write traffic
    peakTracker peaks (
        .clk       (clk),
        .rstN      (rstN),
        .clear     (clear),
        .busy      (busy),
        .peakSel   (peakSel),
        .mem       (memBus.mon),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

endmodule

//--- design/sifhPkg.sv
package sifhPkg;

    // hit timestamp from the TDC
    localparam int stampWidth = 10;

    // upper timestamp bits form the bin index
    // 32 bins per pixel
    localparam int binWidth = 5;

    // pixels sharing one histogram RAM
    localparam int pixelCount = 4;

    // pixel index width, log2 of pixelCount
    localparam int pixelWidth = 2;

    // RAM address is {pixel, bin}
    localparam int addrWidth = pixelWidth + binWidth;

    // one word per pixel and bin
    localparam int ramDepth = 1 << addrWidth;

    // one histogram count
    // saturates at all ones
    localparam int countWidth = 8;

endpackage

//--- sifhHistogram.f
design/sifhPkg.sv
design/histMemIf.sv
design/histRam.sv
design/histogramFsm.sv
design/peakTracker.sv
design/sifhHistogram.sv
tests/sifhHistogram_properties.sv
tests/sifhHistogramTb.sv

//--- tests/sifhHistogramTb.sv
module sifhHistogramTb import sifhPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int binCount = 1 << binWidth;
    localparam int countMax = (1 << countWidth) - 1;
    // hits over all scenarios
    // random idle cycles fall into the slack
    localparam int totalHits = 4 + 10 + 300 + 400 + 50;
    localparam int slackCycles = 600;
    localparam int timeoutCycles = (2 * ramDepth + totalHits + slackCycles) * 2;

    logic                  clk;
    logic                  rstN;
    logic                  clear;
    logic                  wrEn;
    logic [pixelWidth-1:0] pixel;
    logic [stampWidth-1:0] data;
    logic [pixelWidth-1:0] peakSel;
    logic                  busy;
    logic [binWidth-1:0]   peakBin;
    logic [countWidth-1:0] peakCount;

    integer seed = 32'h29e2;
    int     cycleCount = 0;
    // stimulus asks the compare process for a peak check
    bit     checkPending = 1'b0;

    // model histogram and expected peaks
    int modelCount [pixelCount][binCount];
    int expCount   [pixelCount];
    int expBin     [pixelCount];

    sifhHistogram uut (
        .clk       (clk),
        .rstN      (rstN),
        .clear     (clear),
        .wrEn      (wrEn),
        .pixel     (pixel),
        .data      (data),
        .peakSel   (peakSel),
        .busy      (busy),
        .peakBin   (peakBin),
        .peakCount (peakCount)
    );

    bind histogramFsm sifhHistogramProperties props (
        .clk      (clk),
        .rstN     (rstN),
        .clear    (clear),
        .busy     (busy),
        .sweeping (sweeping),
        .wEnable  (mem.wEnable),
        .rEnable  (mem.rEnable),
        .waddr    (mem.waddr),
        .raddr    (mem.raddr)
    );

    always #2 clk = ~clk;

    // peak after a pixel's bin was written with newCount
    // only a strictly greater count moves the peak
    // ties keep the older bin
    function automatic void refPeak(input int bestCount, input int bestBin, input int bin,
                                    input int newCount, output int peakCountOut,
                                    output int peakBinOut);
        peakCountOut = bestCount;
        peakBinOut = bestBin;
        if (newCount > bestCount) begin
            peakCountOut = newCount;
            peakBinOut = bin;
        end
    endfunction

    // one accepted hit into the model with saturating count
    function automatic void recordHit(input int p, input int stamp);
        int bin;
        int newCount;
        bin = stamp >> (stampWidth - binWidth);
        newCount = modelCount[p][bin] + 1;
        if (newCount > countMax) begin
            newCount = countMax;
        end
        modelCount[p][bin] = newCount;
        refPeak(expCount[p], expBin[p], bin, newCount, expCount[p], expBin[p]);
    endfunction

    // empty histogram and peaks back to zero
    function automatic void resetModel();
        for (int p = 0; p < pixelCount; p++) begin
            expCount[p] = 0;
            expBin[p] = 0;
            for (int b = 0; b < binCount; b++) begin
                modelCount[p][b] = 0;
            end
        end
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] observed);
        if (observed !== expected) begin
            $display("FAIL %s expected 0x%0h observed 0x%0h", name, expected, observed);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // hit for one cycle
    // busy is stable at the falling edge
    task automatic driveHit(input int p, input int stamp);
        @(negedge clk);
        wrEn = 1'b1;
        pixel = pixelWidth'(p);
        data = stampWidth'(stamp);
        if (!busy) begin
            recordHit(p, stamp);
        end
    endtask

    task automatic idleCycle();
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic pulseClear();
        @(negedge clk);
        wrEn = 1'b0;
        clear = 1'b1;
        @(negedge clk);
        clear = 1'b0;
        resetModel();
    endtask

    // hand over to the compare process and wait for it
    task automatic requestCheck();
        idleCycle();
        checkPending = 1'b1;
        wait (!checkPending);
    endtask

    // compare process
    // waits out sweep and pipeline
    // then walks peakSel over all pixels
    always begin
        wait (checkPending);
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        for (int p = 0; p < pixelCount; p++) begin
            @(negedge clk);
            peakSel = pixelWidth'(p);
            #1;
            checkValue($sformatf("peakCount[%0d]", p), expCount[p], peakCount);
            checkValue($sformatf("peakBin[%0d]", p), expBin[p], peakBin);
        end
        checkPending = 1'b0;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeoutCycles);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    // bound assertions on the controller
    always @(negedge clk) begin
        if (uut.fsm.props.assertFails != 0) begin
            $display("an assertion on the histogram controller failed");
            $display("TB FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        clear = 1'b0;
        wrEn = 1'b0;
        pixel = '0;
        data = '0;
        peakSel = '0;
        resetModel();
        repeat (2) @(negedge clk);
        rstN = 1'b1;

        // empty after the power-up sweep
        requestCheck();

        // single hits on bins 3, 7 and 12 of pixel 1
        // tie keeps bin 3
        driveHit(1, (3 << 5) | 1);
        idleCycle();
        driveHit(1, (7 << 5) | 9);
        idleCycle();
        driveHit(1, (12 << 5) | 31);
        requestCheck();
        // second hit on bin 12 takes the peak
        driveHit(1, (12 << 5) | 4);
        requestCheck();

        // back-to-back hits on one bin need forwarding
        repeat (10) driveHit(2, (20 << 5) | 7);
        requestCheck();

        // saturation at the top count
        repeat (300) driveHit(3, (5 << 5) | 2);
        requestCheck();

        // random hits over all pixels with some idle gaps
        for (int i = 0; i < 400; i++) begin
            driveHit($random(seed) & (pixelCount - 1), $random(seed) & ((1 << stampWidth) - 1));
            if (($random(seed) & 3) == 0) begin
                idleCycle();
            end
        end
        requestCheck();

        // clear and then a fresh histogram
        pulseClear();
        requestCheck();
        for (int i = 0; i < 50; i++) begin
            driveHit($random(seed) & (pixelCount - 1), $random(seed) & ((1 << stampWidth) - 1));
        end
        requestCheck();

        if (uut.fsm.props.assertFails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tests/sifhHistogram_properties.sv
module sifhHistogramProperties import sifhPkg::*; (
    input logic                 clk,
    input logic                 rstN,
    input logic                 clear,
    input logic                 busy,
    input logic                 sweeping,
    input logic                 wEnable,
    input logic                 rEnable,
    input logic [addrWidth-1:0] waddr,
    input logic [addrWidth-1:0] raddr
);
    timeunit 1ns;
    timeprecision 100ps;

    // number of failed assertions
    int assertFails = 0;

    // sweep starts on the first edge after reset release
    busyAfterReset: assert property (@(posedge clk) $rose(rstN) |=> busy)
        else begin
            $error("busy not raised on the first cycle after reset");
            assertFails++;
        end

    // a pipeline write goes back to the address read one cycle earlier
    writeAddrFollowsRead: assert property (@(posedge clk) disable iff (!rstN)
        (wEnable && !sweeping) |-> (waddr == $past(raddr)))
        else begin
            $error("pipeline write address differs from the preceding read address");
            assertFails++;
        end

    // every write is a sweep write or follows a read
    writeAfterRead: assert property (@(posedge clk) disable iff (!rstN)
        wEnable |-> (sweeping || $past(rEnable)))
        else begin
            $error("RAM write without a preceding read or sweep");
            assertFails++;
        end

    // accepted clear gives one full sweep before busy drops
    clearSweepLength: assert property (@(posedge clk) disable iff (!rstN)
        (clear && !busy) |=> busy [*ramDepth] ##1 !busy)
        else begin
            $error("busy length after clear differs from the RAM depth");
            assertFails++;
        end

endmodule
